/* Bender.yml */
package:
  name: branch_predict

sources:
  - verilog/branchPkg.sv
  - verilog/predictionIf.sv
  - verilog/branchTargetBuffer.sv
  - verilog/branchCounters.sv
  - verilog/fetchSequencer.sv
  - verilog/branchPredictUnit.sv
  - target: simulation
    files:
      - sim/branchPredict_checker.sv
      - sim/branchPredictTb.sv

/* sim/branchPredictTb.sv */
`timescale 1ns/1ps

module branchPredictTb;

    logic clk;
    logic rst;
    logic stall;
    logic redirectValid;
    logic [30:0] redirectPc;
    logic updValid;
    logic updClean;
    logic [31:0] updSrc;
    logic [31:0] updDst;
    branchPkg::FetchOff_t updFetchStartOffs;
    logic updIsJump;
    logic updIsCall;
    logic updCompressed;
    logic updMultiple;
    branchPkg::FetchOff_t updMultipleOffs;
    logic ctrValid;
    logic [30:0] ctrPc;
    logic ctrTaken;
    logic fetchValid;
    logic [30:0] fetchPc;
    logic predTaken;
    logic [30:0] predDst;
    logic predFound;
    logic predIsCall;
    logic predCompr;

    string cmdLines[$];                              // Command lines from the test file.
    bit testOk;
    int testNum = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    int cycleLimit = 20;

    // Expected buffer contents, kept from the update lines.
    bit modelValid [branchPkg::BTB_ENTRIES];
    bit modelMult [branchPkg::BTB_ENTRIES];
    logic [branchPkg::BTB_TAG_SIZE-1:0] modelTag [branchPkg::BTB_ENTRIES];
    branchPkg::FetchOff_t modelOffs [branchPkg::BTB_ENTRIES];
    bit modelCall [branchPkg::BTB_ENTRIES];
    bit modelCompr [branchPkg::BTB_ENTRIES];
    logic [30:0] nextExpPc;                          // Fetch after the last expected line.

    branchPredictUnit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                       // 10 ns period.
    end

    // Run limit grows with the number of command lines.
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the test list did not finish within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************

    task automatic clearInputs();
        stall = 1'b0;
        redirectValid = 1'b0;
        redirectPc = '0;
        updValid = 1'b0;
        updClean = 1'b0;
        updSrc = '0;
        updDst = '0;
        updFetchStartOffs = '0;
        updIsJump = 1'b0;
        updIsCall = 1'b0;
        updCompressed = 1'b0;
        updMultiple = 1'b0;
        updMultipleOffs = '0;
        ctrValid = 1'b0;
        ctrPc = '0;
        ctrTaken = 1'b0;
    endtask

    task automatic loadTests();
        int fd;
        string line;
        fd = $fopen("sim/branchTests.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#")
                    cmdLines.push_back(line);        // Comments and blank lines dropped.
            end
            $fclose(fd);
        end
    endtask

    // Index is PC bits [4:3] with the fetch start, tag the 8 PC bits above it.
    task automatic recordUpdate();
        logic [branchPkg::BTB_IDX_BITS-1:0] idx;
        idx = {updSrc[5:4], updFetchStartOffs};
        if (updClean) begin
            modelValid[idx] = 1'b0;
        end else begin
            if (updMultiple) begin
                modelMult[idx] = 1'b1;               // Earlier branch ends the block.
                idx[2:0] = updMultipleOffs;
            end
            modelValid[idx] = 1'b1;
            modelMult[idx] = 1'b0;
            modelTag[idx] = updSrc[13:6];
            modelOffs[idx] = updSrc[3:1];
            modelCall[idx] = updIsCall;
            modelCompr[idx] = updCompressed;
        end
    endtask

    function automatic bit bufferHit(logic [30:0] pc);
        return modelValid[pc[4:0]] && modelTag[pc[4:0]] == pc[12:5];
    endfunction

    function automatic logic [30:0] nextFetchPc(logic [30:0] pc, logic tk, logic [30:0] dst);
        logic [3:0] brEnd;
        brEnd = {1'b0, modelOffs[pc[4:0]]} + (modelCompr[pc[4:0]] ? 4'd1 : 4'd2);
        if (tk)
            return dst;
        if (bufferHit(pc) && modelMult[pc[4:0]] && brEnd < 4'd8)
            return {pc[30:3], brEnd[2:0]};           // End of the earlier branch.
        return {pc[30:3] + 28'd1, 3'b000};
    endfunction

    task automatic checkField(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
            testOk = 1'b0;
        end
    endtask

    task automatic finishTest(string what);
        testNum++;
        if (testOk) begin
            passCount++;
            $display("Test %0d (%s) passed", testNum, what);
        end else begin
            failCount++;
            $display("Test %0d (%s) failed", testNum, what);
        end
    endtask

    // One line is one cycle; a stall line takes its count plus a resume cycle.
    task automatic runCommand(string line);
        byte cmd;
        logic [31:0] f [9];
        logic [30:0] heldPc;
        logic [4:0] idx;
        void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h", cmd,
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]));
        case (cmd)
            "U": begin
                updValid = 1'b1;
                updClean = f[0][0];
                updSrc = f[1];
                updDst = f[2];
                updFetchStartOffs = f[3][2:0];
                updIsJump = f[4][0];
                updIsCall = f[5][0];
                updCompressed = f[6][0];
                updMultiple = f[7][0];
                updMultipleOffs = f[8][2:0];
                recordUpdate();
            end
            "C": begin
                ctrValid = 1'b1;
                ctrPc = f[0][30:0];
                ctrTaken = f[1][0];
            end
            "R": begin
                redirectValid = 1'b1;
                redirectPc = f[0][30:0];
            end
            "E": begin
                testOk = 1'b1;                       // Outputs settled at the last rising edge.
                idx = f[0][4:0];
                checkField("fetchValid", {31'b0, fetchValid}, 32'd1);
                checkField("fetchPc", {1'b0, fetchPc}, f[0]);
                checkField("predTaken", {31'b0, predTaken}, f[1]);
                if (f[1][0])
                    checkField("predDst", {1'b0, predDst}, f[2]);
                checkField("predFound", {31'b0, predFound}, {31'b0, bufferHit(f[0][30:0])});
                if (bufferHit(f[0][30:0])) begin
                    checkField("predIsCall", {31'b0, predIsCall}, {31'b0, modelCall[idx]});
                    checkField("predCompr", {31'b0, predCompr}, {31'b0, modelCompr[idx]});
                end
                nextExpPc = nextFetchPc(f[0][30:0], f[1][0], f[2][30:0]);
                finishTest($sformatf("fetch %h", f[0]));
            end
            "S": begin
                testOk = 1'b1;
                stall = 1'b1;
                heldPc = nextExpPc;                  // Fetch issued after the line before.
                repeat (f[0] - 1) begin
                    @(negedge clk);
                    checkField("fetchValid", {31'b0, fetchValid}, 32'd0);
                    checkField("fetchPc", {1'b0, fetchPc}, {1'b0, heldPc});
                end
                @(negedge clk);
                stall = 1'b0;                        // Resume cycle.
                checkField("fetchValid", {31'b0, fetchValid}, 32'd0);
                checkField("fetchPc", {1'b0, fetchPc}, {1'b0, heldPc});
                finishTest($sformatf("stall %0d cycles", f[0]));
            end
            default: begin
                $display("Unknown command in the test file: %s", line);
                testOk = 1'b0;
                finishTest("unknown command");
            end
        endcase
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************

    initial begin
        rst = 1'b1;
        clearInputs();
        loadTests();
        cycleLimit = 4 * cmdLines.size() + 20;
        if (cmdLines.size() == 0) begin
            $display("No commands could be read from sim/branchTests.txt");
            failCount++;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (cmdLines[i]) begin
            @(negedge clk);
            clearInputs();
            runCommand(cmdLines[i]);
        end
        @(negedge clk);
        clearInputs();
        $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 testNum, passCount, failCount, dut_i.rules_i.assertFails);
        if (failCount == 0 && dut_i.rules_i.assertFails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* sim/branchPredict_checker.sv */
`timescale 1ns/1ps

module branchPredictChecker (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic fetchValid,
    input logic predTaken,
    input logic predFound
);

    int assertFails = 0;                             // Read by the testbench at the end.

    // ************************************************************************
    // Fetch output rules
    // ************************************************************************

    resetQuiet: assert property (@(posedge clk) rst |=> !fetchValid)
        else begin
            $error("fetchValid high during reset or in the cycle after it");
            assertFails++;
        end

    stallQuiet: assert property (@(posedge clk) disable iff (rst) stall |=> !fetchValid)
        else begin
            $error("fetchValid high in the cycle after a stall cycle");
            assertFails++;
        end

    takenNeedsHit: assert property (@(posedge clk) disable iff (rst) predTaken |-> predFound)
        else begin
            $error("predTaken high without a buffer hit");
            assertFails++;
        end

endmodule

bind branchPredictUnit branchPredictChecker rules_i (.*);

/* sim/branchTests.txt */
# U clean src dst fetchStartOffs isJump isCall compressed multiple multipleOffs (byte addresses)
# C pc taken | R pc | S cycles | E fetchPc taken dst (halfword PCs), all fields hex
R 43
E 43 0 0
E 48 0 0
E 50 0 0
U 0 204 400 0 1 1 0 0 0
R 100
E 100 1 200
E 200 0 0
E 208 0 0
U 0 250 600 0 0 0 0 0 0
R 128
E 128 1 300
E 300 0 0
C 128 0
C 128 0
R 128
E 128 0 0
E 130 0 0
U 0 2a2 800 0 0 0 0 0 0
U 0 2a8 a00 0 1 0 0 1 3
C 150 0
R 150
E 150 0 0
E 153 1 500
E 500 0 0
E 508 0 0
R 100
E 100 1 200
U 1 204 0 0 0 0 0 0 0
R 100
E 100 0 0
E 108 0 0
R 40
E 40 0 0
E 48 0 0
S 4
E 58 0 0
E 60 0 0

/* src.f */
verilog/branchPkg.sv
verilog/predictionIf.sv
verilog/branchTargetBuffer.sv
verilog/branchCounters.sv
verilog/fetchSequencer.sv
verilog/branchPredictUnit.sv
sim/branchPredict_checker.sv
sim/branchPredictTb.sv

/* verilog/branchCounters.sv */
`timescale 1ns/1ps

module branchCounters (
    input  logic clk,
    input  logic rst,
    input  logic lookupValid,
    input  logic [30:0] lookupPc,
    input  branchPkg::CtrUpdate update,
    output logic predTaken
);

    logic [1:0] counters [branchPkg::BTB_ENTRIES];
    logic [1:0] readCtr;
    logic [branchPkg::BTB_IDX_BITS-1:0] updIdx;
    logic [1:0] curCtr;

    assign updIdx = update.pc[branchPkg::BTB_IDX_BITS-1:0];
    assign curCtr = counters[updIdx];

    // ************************************************************************
    // Training with saturating 2-bit counters
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < branchPkg::BTB_ENTRIES; i++)
                counters[i] <= 2'd2;                 // Weakly taken.
        end else if (update.valid) begin
            if (update.taken) begin
                if (curCtr != 2'd3)
                    counters[updIdx] <= curCtr + 2'd1;
            end else begin
                if (curCtr != 2'd0)
                    counters[updIdx] <= curCtr - 2'd1;
            end
        end
    end

    // Read has the same one cycle latency as the buffer.
    always_ff @(posedge clk) begin
        if (lookupValid)
            readCtr <= counters[lookupPc[branchPkg::BTB_IDX_BITS-1:0]];
    end

    assign predTaken = readCtr[1];                   // Taken at 2 or 3.

endmodule

/* verilog/branchPkg.sv */
package branchPkg;

    // ************************************************************************
    // Sizes of the prediction tables
    // ************************************************************************

    localparam int BTB_ENTRIES = 32;                 // Buffer and counter entries.
    localparam int BTB_IDX_BITS = 5;                 // Index width, log2 of the entries.
    localparam int BTB_TAG_SIZE = 8;                 // Tag bits above the index.
    localparam int FETCH_OFF_BITS = 3;               // Halfwords in a 16 byte block.

    // Halfword offset inside a fetch block.
    typedef logic [FETCH_OFF_BITS-1:0] FetchOff_t;

    // ************************************************************************
    // Write ports from the backend
    // ************************************************************************

    typedef struct packed {
        logic valid;
        logic clean;                                 // Invalidate the entry.
        logic [31:0] src;                            // Byte address of the branch.
        logic [31:0] dst;                            // Byte address of the target.
        FetchOff_t fetchStartOffs;                   // Where the fetch began.
        logic isJump;
        logic isCall;
        logic compressed;
        logic multiple;                              // Earlier branch in this block.
        FetchOff_t multipleOffs;                     // Offset of the following branch.
    } BTUpdate;

    typedef struct packed {
        logic valid;
        logic [30:0] pc;                             // Halfword PC of the branch.
        logic taken;
    } CtrUpdate;

endpackage

/* verilog/branchPredictUnit.sv */
`timescale 1ns/1ps

module branchPredictUnit (
    input  logic clk,
    input  logic rst,

    input  logic stall,
    input  logic redirectValid,
    input  logic [30:0] redirectPc,

    input  logic updValid,
    input  logic updClean,
    input  logic [31:0] updSrc,
    input  logic [31:0] updDst,
    input  branchPkg::FetchOff_t updFetchStartOffs,
    input  logic updIsJump,
    input  logic updIsCall,
    input  logic updCompressed,
    input  logic updMultiple,
    input  branchPkg::FetchOff_t updMultipleOffs,

    input  logic ctrValid,
    input  logic [30:0] ctrPc,
    input  logic ctrTaken,

    output logic fetchValid,
    output logic [30:0] fetchPc,
    output logic predTaken,
    output logic [30:0] predDst,
    output logic predFound,
    output logic predIsCall,
    output logic predCompr
);

    branchPkg::BTUpdate btUpdate;
    branchPkg::CtrUpdate ctrUpdate;
    logic lookupValid;
    logic [30:0] lookupPc;
    logic counterTaken;

    predictionIf predIf ();

    // ************************************************************************
    // Pack the backend ports
    // ************************************************************************

    always_comb begin
        btUpdate.valid = updValid;
        btUpdate.clean = updClean;
        btUpdate.src = updSrc;
        btUpdate.dst = updDst;
        btUpdate.fetchStartOffs = updFetchStartOffs;
        btUpdate.isJump = updIsJump;
        btUpdate.isCall = updIsCall;
        btUpdate.compressed = updCompressed;
        btUpdate.multiple = updMultiple;
        btUpdate.multipleOffs = updMultipleOffs;
    end

    assign ctrUpdate = '{valid: ctrValid, pc: ctrPc, taken: ctrTaken};

    branchTargetBuffer btb_i (
        .clk(clk), .rst(rst),
        .lookupValid(lookupValid), .lookupPc(lookupPc),
        .update(btUpdate), .pred(predIf.source)
    );

    branchCounters ctrs_i (
        .clk(clk), .rst(rst),
        .lookupValid(lookupValid), .lookupPc(lookupPc),
        .update(ctrUpdate), .predTaken(counterTaken)
    );

    fetchSequencer seq_i (
        .clk(clk), .rst(rst), .stall(stall),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .pred(predIf.sink), .predTaken(counterTaken),
        .lookupValid(lookupValid), .lookupPc(lookupPc),
        .fetchValid(fetchValid), .fetchPc(fetchPc), .taken(predTaken)
    );

    assign predDst = predIf.dst;                     // Prediction for the current fetch.
    assign predFound = predIf.found;
    assign predIsCall = predIf.isCall;
    assign predCompr = predIf.compr;

endmodule

/* verilog/branchTargetBuffer.sv */
`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic clk,
    input  logic rst,
    input  logic lookupValid,
    input  logic [30:0] lookupPc,
    input  branchPkg::BTUpdate update,
    predictionIf.source pred
);

    typedef struct packed {
        logic isJump;
        logic isCall;
        logic compr;
        logic [30:0] dst;
        logic [branchPkg::BTB_TAG_SIZE-1:0] tag;
        branchPkg::FetchOff_t offs;
    } BtbEntry_t;

    BtbEntry_t entries [branchPkg::BTB_ENTRIES];
    logic [branchPkg::BTB_ENTRIES-1:0] validBits;
    logic [branchPkg::BTB_ENTRIES-1:0] multipleBits;

    BtbEntry_t readEntry;
    logic readValid;
    logic readMultiple;
    logic [30:0] readPc;

    logic [branchPkg::BTB_IDX_BITS-1:0] lookupIdx;
    logic [branchPkg::BTB_IDX_BITS-1:0] baseIdx;
    logic [branchPkg::BTB_IDX_BITS-1:0] writeIdx;
    BtbEntry_t newEntry;

    // ************************************************************************
    // Lookup, tag check after the read register
    // ************************************************************************

    assign lookupIdx = lookupPc[branchPkg::BTB_IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            readEntry <= entries[lookupIdx];         // Plain synchronous read.
            readPc <= lookupPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
            readMultiple <= 1'b0;
        end else if (lookupValid) begin
            readValid <= validBits[lookupIdx];
            readMultiple <= multipleBits[lookupIdx];
        end
    end

    always_comb begin
        pred.found = 1'b0;
        pred.dst = '0;
        pred.offs = '0;
        pred.isJump = 1'b0;
        pred.isCall = 1'b0;
        pred.compr = 1'b0;
        pred.multiple = 1'b0;
        if (readValid &&
            readEntry.tag == readPc[branchPkg::BTB_IDX_BITS +: branchPkg::BTB_TAG_SIZE]) begin
            pred.found = 1'b1;
            pred.dst = readEntry.dst;
            pred.offs = readEntry.offs;
            pred.isJump = readEntry.isJump;
            pred.isCall = readEntry.isCall;
            pred.compr = readEntry.compr;
            pred.multiple = readMultiple;
        end
    end

    // ************************************************************************
    // Update from the backend
    // ************************************************************************

    always_comb begin
        baseIdx = {update.src[branchPkg::BTB_IDX_BITS:branchPkg::FETCH_OFF_BITS+1],
                   update.fetchStartOffs};
        writeIdx = baseIdx;
        if (update.multiple)
            writeIdx[branchPkg::FETCH_OFF_BITS-1:0] = update.multipleOffs; // Next branch slot.
    end

    always_comb begin
        newEntry.isJump = update.isJump;
        newEntry.isCall = update.isCall;
        newEntry.compr = update.compressed;
        newEntry.dst = update.dst[31:1];
        newEntry.tag = update.src[branchPkg::BTB_IDX_BITS+1 +: branchPkg::BTB_TAG_SIZE];
        newEntry.offs = update.src[1 +: branchPkg::FETCH_OFF_BITS];
    end

    always_ff @(posedge clk) begin
        if (update.valid && !update.clean)
            entries[writeIdx] <= newEntry;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            multipleBits <= '0;
        end else if (update.valid) begin
            if (update.clean) begin
                validBits[baseIdx] <= 1'b0;
            end else begin
                if (update.multiple)
                    multipleBits[baseIdx] <= 1'b1;   // Earlier branch ends the block.
                validBits[writeIdx] <= 1'b1;
                multipleBits[writeIdx] <= 1'b0;
            end
        end
    end

endmodule

/* verilog/fetchSequencer.sv */
`timescale 1ns/1ps

module fetchSequencer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirectValid,
    input  logic [30:0] redirectPc,
    predictionIf.sink pred,
    input  logic predTaken,
    output logic lookupValid,
    output logic [30:0] lookupPc,
    output logic fetchValid,
    output logic [30:0] fetchPc,
    output logic taken
);

    logic running;
    logic pendRedirect;                              // Redirect arrived during a stall.
    logic [30:0] lastPc;
    logic [30-branchPkg::FETCH_OFF_BITS:0] nextBlock;
    logic [branchPkg::FETCH_OFF_BITS:0] branchEnd;
    logic [30:0] nextPc;

    assign taken = pred.found && (pred.isJump || predTaken);
    assign nextBlock = lastPc[30:branchPkg::FETCH_OFF_BITS] + 1'b1;
    assign branchEnd = {1'b0, pred.offs} + (pred.compr ? 4'd1 : 4'd2);

    // ************************************************************************
    // Next PC from the previous lookup
    // ************************************************************************

    always_comb begin
        nextPc = {nextBlock, {branchPkg::FETCH_OFF_BITS{1'b0}}};    // Sequential block.
        if (taken)
            nextPc = pred.dst;
        else if (pred.found && pred.multiple && !branchEnd[branchPkg::FETCH_OFF_BITS])
            nextPc = {lastPc[30:branchPkg::FETCH_OFF_BITS],
                      branchEnd[branchPkg::FETCH_OFF_BITS-1:0]};   // Rest of the block.
    end

    assign lookupValid = !stall && (redirectValid || running);
    assign lookupPc = redirectValid ? redirectPc : (pendRedirect ? lastPc : nextPc);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pendRedirect <= 1'b0;
            lastPc <= '0;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= lookupValid;
            if (redirectValid)
                running <= 1'b1;
            if (lookupValid) begin
                lastPc <= lookupPc;
                pendRedirect <= 1'b0;
            end else if (redirectValid) begin
                lastPc <= redirectPc;                // Issued once the stall ends.
                pendRedirect <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid)
            fetchPc <= lookupPc;
    end

endmodule

/* verilog/predictionIf.sv */
`timescale 1ns/1ps

// One lookup result, valid in the cycle after the lookup.
interface predictionIf;

    logic found;                                     // Tag matched a valid entry.
    logic [30:0] dst;                                // Halfword target.
    branchPkg::FetchOff_t offs;                      // Offset of the branch in its block.
    logic isJump;
    logic isCall;
    logic compr;
    logic multiple;                                  // Another branch follows in the block.

    modport source (
        output found, dst, offs, isJump, isCall, compr, multiple
    );

    modport sink (
        input found, dst, offs, isJump, isCall, compr, multiple
    );

endinterface
